//--- uart_frame_pkg.sv
// command frame protocol constants, byte type and frame index type

`default_nettype none

package uart_frame_pkg;

    // ----------------------------------------
    // basic types
    typedef logic [7:0] byte_t;          // one uart byte
    typedef logic [4:0] frame_idx_t;     // position in frame, 0..17

    // ----------------------------------------
    // frame layout
    localparam byte_t      HDR_BYTE_0 = 8'hAF;     // first header byte
    localparam byte_t      HDR_BYTE_1 = 8'hFA;     // second header byte
    localparam frame_idx_t LEN_IDX    = 5'd2;      // length byte position

    localparam int MAX_PAYLOAD = 15;                // largest L accepted
    localparam int FRAME_DEPTH = MAX_PAYLOAD + 3;   // header, length and payload

    // command fields inside the payload
    localparam frame_idx_t CMD_IDX   = 5'd3;       // channel code
    localparam frame_idx_t VALUE_IDX = 5'd4;       // voltage byte

    // transmit pacing
    localparam int TX_GAP_CYCLES = 2;               // hold-off after each strobe

endpackage

`default_nettype wire

//--- pulse_ctrl_pkg.sv
// capacitor channel codes and voltage setpoint type for the pulsed-power controller

`default_nettype none

package pulse_ctrl_pkg;

    // ----------------------------------------
    // setpoint and command types
    typedef logic [7:0] volt_t;          // capacitor voltage setpoint
    typedef logic [7:0] chan_code_t;     // channel select code

    // ----------------------------------------
    // channel codes carried in payload byte 0
    localparam chan_code_t CH_RES_1   = 8'd1;   // resonant capacitor 1
    localparam chan_code_t CH_RES_2   = 8'd2;   // resonant capacitor 2
    localparam chan_code_t CH_SUPPORT = 8'd3;   // support capacitor

    // any other code leaves the setpoints alone

endpackage

`default_nettype wire

//--- frame_decoder.sv
// frame decoder with recv_done edge detect, header hunt, length check and byte indexing

`timescale 1ns/1ps
`default_nettype none

module frame_decoder (
    input  wire                        sys_clk,
    input  wire                        sys_rst_n,
    input  wire                        recv_done,
    input  wire uart_frame_pkg::byte_t recv_data,
    input  wire                        echo_busy,
    output logic                       byte_wr,
    output uart_frame_pkg::frame_idx_t byte_idx,
    output uart_frame_pkg::byte_t      byte_data,
    output logic                       frame_done,
    output uart_frame_pkg::byte_t      frame_len
);

    import uart_frame_pkg::*;

    typedef enum logic [1:0] {
        ST_HUNT,
        ST_HDR2,
        ST_LEN,
        ST_PAYLOAD
    } dec_state_t;

    dec_state_t state;
    logic       recv_d0;
    logic       recv_d1;
    logic       recv_rise;
    logic       last_wr;       // last payload byte went out this cycle
    logic       len_ok;
    byte_t      len_reg;       // L of the frame being received
    frame_idx_t next_idx;
    frame_idx_t last_idx;

    // ----------------------------------------
    // recv_done sync and rising edge
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            recv_d0 <= 1'b0;
            recv_d1 <= 1'b0;
        end else begin
            recv_d0 <= recv_done;
            recv_d1 <= recv_d0;
        end
    end

    assign recv_rise = recv_d0 & ~recv_d1;
    assign len_ok    = (recv_data != '0) && (recv_data <= byte_t'(MAX_PAYLOAD));
    assign next_idx  = byte_idx + 5'd1;
    assign last_idx  = frame_idx_t'(len_reg) + LEN_IDX;   // index of final payload byte

    // ----------------------------------------
    // hunt / header / length / payload FSM
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= ST_HUNT;
            byte_wr    <= 1'b0;
            byte_idx   <= '0;
            len_reg    <= '0;
            frame_len  <= '0;
            last_wr    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            byte_wr    <= 1'b0;
            last_wr    <= 1'b0;
            frame_done <= last_wr;            // one cycle after the last write
            if (echo_busy) begin
                state <= ST_HUNT;             // input dropped while echoing
            end else if (recv_rise) begin
                case (state)
                    ST_HUNT: begin
                        if (recv_data == HDR_BYTE_0) begin
                            state    <= ST_HDR2;
                            byte_wr  <= 1'b1;
                            byte_idx <= '0;
                        end
                    end
                    ST_HDR2: begin
                        if (recv_data == HDR_BYTE_1) begin
                            state    <= ST_LEN;
                            byte_wr  <= 1'b1;
                            byte_idx <= 5'd1;
                        end else begin
                            state <= ST_HUNT;   // no recheck for AF here
                        end
                    end
                    ST_LEN: begin
                        if (len_ok) begin
                            state    <= ST_PAYLOAD;
                            byte_wr  <= 1'b1;
                            byte_idx <= LEN_IDX;
                            len_reg  <= recv_data;
                        end else begin
                            state <= ST_HUNT;   // L out of range
                        end
                    end
                    ST_PAYLOAD: begin
                        byte_wr  <= 1'b1;
                        byte_idx <= next_idx;
                        if (next_idx == last_idx) begin
                            state     <= ST_HUNT;
                            last_wr   <= 1'b1;
                            frame_len <= len_reg;   // held until the next frame
                        end
                    end
                    default: state <= ST_HUNT;
                endcase
            end
        end
    end

    // data follows the edge strobe
    always_ff @(posedge sys_clk) begin
        if (recv_rise) begin
            byte_data <= recv_data;
        end
    end

endmodule

`default_nettype wire

//--- frame_exec.sv
// frame store with read port and capacitor-voltage command execution

`timescale 1ns/1ps
`default_nettype none

module frame_exec (
    input  wire                             sys_clk,
    input  wire                             sys_rst_n,
    input  wire                             byte_wr,
    input  wire uart_frame_pkg::frame_idx_t byte_idx,
    input  wire uart_frame_pkg::byte_t      byte_data,
    input  wire                             frame_done,
    input  wire uart_frame_pkg::byte_t      frame_len,
    input  wire uart_frame_pkg::frame_idx_t rd_idx,
    output uart_frame_pkg::byte_t           rd_data,
    output pulse_ctrl_pkg::volt_t           cap_set_res_1,
    output pulse_ctrl_pkg::volt_t           cap_set_res_2,
    output pulse_ctrl_pkg::volt_t           cap_set_support
);

    import uart_frame_pkg::*;
    import pulse_ctrl_pkg::*;

    byte_t      frame_mem [FRAME_DEPTH];   // whole frame incl. header
    chan_code_t cmd_code;
    volt_t      cmd_value;
    logic       cmd_valid;

    // ----------------------------------------
    // frame storage
    always_ff @(posedge sys_clk) begin
        if (byte_wr) begin
            frame_mem[byte_idx] <= byte_data;
        end
    end

    assign rd_data = frame_mem[rd_idx];   // async read for the sender

    // ----------------------------------------
    // command decode
    assign cmd_code  = chan_code_t'(frame_mem[CMD_IDX]);
    assign cmd_value = volt_t'(frame_mem[VALUE_IDX]);

    // needs both code and value bytes in the payload
    assign cmd_valid = frame_done && (frame_len >= byte_t'(VALUE_IDX - LEN_IDX));

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cap_set_res_1   <= '0;
            cap_set_res_2   <= '0;
            cap_set_support <= '0;
        end else if (cmd_valid) begin
            case (cmd_code)
                CH_RES_1:   cap_set_res_1   <= cmd_value;
                CH_RES_2:   cap_set_res_2   <= cmd_value;
                CH_SUPPORT: cap_set_support <= cmd_value;
                default: begin
                    // unknown channel, setpoints kept
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- echo_sender.sv
// paced echo of the stored frame to the uart transmitter

`timescale 1ns/1ps
`default_nettype none

module echo_sender (
    input  wire                        sys_clk,
    input  wire                        sys_rst_n,
    input  wire                        frame_done,
    input  wire uart_frame_pkg::byte_t frame_len,
    input  wire uart_frame_pkg::byte_t rd_data,
    input  wire                        tx_busy,
    output uart_frame_pkg::frame_idx_t rd_idx,
    output logic                       send_en,
    output uart_frame_pkg::byte_t      send_data,
    output logic                       echo_busy
);

    import uart_frame_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,     // waiting for tx_busy low
        ST_GAP       // hold-off after a strobe
    } snd_state_t;

    snd_state_t state;
    frame_idx_t send_idx;
    frame_idx_t last_idx;
    logic [1:0] gap_cnt;
    logic       gap_done;

    // ----------------------------------------
    // outputs
    assign rd_idx    = send_idx;
    assign send_data = rd_data;
    assign send_en   = (state == ST_WAIT) && !tx_busy;   // single-cycle strobe
    assign echo_busy = (state != ST_IDLE);
    assign gap_done  = (gap_cnt == 2'(TX_GAP_CYCLES - 1));

    // ----------------------------------------
    // idle / wait / gap FSM
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= ST_IDLE;
            send_idx <= '0;
            last_idx <= '0;
            gap_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_done) begin
                        state    <= ST_WAIT;
                        send_idx <= '0;
                        last_idx <= frame_idx_t'(frame_len) + LEN_IDX;   // L+3 bytes
                    end
                end
                ST_WAIT: begin
                    if (send_en) begin
                        state   <= ST_GAP;
                        gap_cnt <= '0;
                    end
                end
                ST_GAP: begin
                    if (gap_done) begin
                        if (send_idx == last_idx) begin
                            state <= ST_IDLE;        // whole frame echoed
                        end else begin
                            state    <= ST_WAIT;
                            send_idx <= send_idx + 5'd1;
                        end
                    end else begin
                        gap_cnt <= gap_cnt + 2'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_echo_top.sv
// top level joining frame decoder, frame executor and echo sender

`timescale 1ns/1ps
`default_nettype none

module uart_echo_top (
    input  wire                        sys_clk,
    input  wire                        sys_rst_n,
    input  wire                        recv_done,
    input  wire uart_frame_pkg::byte_t recv_data,
    input  wire                        tx_busy,
    output logic                       send_en,
    output uart_frame_pkg::byte_t      send_data,
    output pulse_ctrl_pkg::volt_t      cap_set_res_1,
    output pulse_ctrl_pkg::volt_t      cap_set_res_2,
    output pulse_ctrl_pkg::volt_t      cap_set_support
);

    import uart_frame_pkg::*;

    logic       byte_wr;
    frame_idx_t byte_idx;
    byte_t      byte_data;
    logic       frame_done;
    byte_t      frame_len;
    frame_idx_t rd_idx;
    byte_t      rd_data;
    logic       echo_busy;     // sender active, decoder holds off

    // ----------------------------------------
    // decode, execute, echo
    frame_decoder frame_decoder_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .recv_done  (recv_done),
        .recv_data  (recv_data),
        .echo_busy  (echo_busy),
        .byte_wr    (byte_wr),
        .byte_idx   (byte_idx),
        .byte_data  (byte_data),
        .frame_done (frame_done),
        .frame_len  (frame_len)
    );

    frame_exec frame_exec_i (
        .sys_clk         (sys_clk),
        .sys_rst_n       (sys_rst_n),
        .byte_wr         (byte_wr),
        .byte_idx        (byte_idx),
        .byte_data       (byte_data),
        .frame_done      (frame_done),
        .frame_len       (frame_len),
        .rd_idx          (rd_idx),
        .rd_data         (rd_data),
        .cap_set_res_1   (cap_set_res_1),
        .cap_set_res_2   (cap_set_res_2),
        .cap_set_support (cap_set_support)
    );

    echo_sender echo_sender_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .frame_done (frame_done),
        .frame_len  (frame_len),
        .rd_data    (rd_data),
        .tx_busy    (tx_busy),
        .rd_idx     (rd_idx),
        .send_en    (send_en),
        .send_data  (send_data),
        .echo_busy  (echo_busy)
    );

endmodule

`default_nettype wire

//--- uart_echo_checker.sv
// concurrent assertions on the transmit handshake, bound to uart_echo_top

`timescale 1ns/1ps
`default_nettype none

module uart_echo_checker (
    input wire sys_clk,
    input wire sys_rst_n,
    input wire send_en,
    input wire tx_busy
);

    import uart_frame_pkg::*;

    // ----------------------------------------
    // transmit handshake
    no_send_while_busy: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        send_en |-> !tx_busy
    ) else $error("send_en while tx_busy high");

    send_one_cycle: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        send_en |=> !send_en
    ) else $error("send_en wider than one cycle");

    // hold-off after each strobe
    send_gap: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        send_en |=> !send_en [*TX_GAP_CYCLES]
    ) else $error("send_en inside the gap");

    quiet_in_reset: assert property (
        @(posedge sys_clk)
        !sys_rst_n |-> !send_en
    ) else $error("send_en during reset");

endmodule

bind uart_echo_top uart_echo_checker uart_echo_checker_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .send_en   (send_en),
    .tx_busy   (tx_busy)
);

`default_nettype wire

//--- tb_uart_echo.sv
// testbench for uart_echo_top with random frames, transmitter model and reference model

`timescale 1ns/1ps
`default_nettype none

module tb_uart_echo;

    import uart_frame_pkg::*;
    import pulse_ctrl_pkg::*;

    localparam int NUM_FRAMES   = 64;     // upper bound on frames sent
    localparam int FRAME_CYCLES = 700;    // worst case receive plus paced echo

    logic  sys_clk   = 1'b0;
    logic  sys_rst_n = 1'b0;
    logic  recv_done = 1'b0;
    byte_t recv_data = '0;
    logic  tx_busy   = 1'b0;
    logic  send_en;
    byte_t send_data;
    volt_t cap_set_res_1;
    volt_t cap_set_res_2;
    volt_t cap_set_support;

    integer seed = 81;
    int     error_count = 0;
    int     check_count = 0;
    int     strobe_cnt  = 0;     // strobes seen by the monitor
    int     served_cnt  = 0;     // strobes answered by the tx model
    int     busy_cnt    = 0;
    byte_t  frm[$];              // frame about to be sent
    byte_t  exp_q[$];            // predicted echo
    byte_t  rx_q[$];             // echo collected from send_en
    volt_t  exp_res_1   = '0;
    volt_t  exp_res_2   = '0;
    volt_t  exp_support = '0;

    always #5 sys_clk = ~sys_clk;

    uart_echo_top uart_echo_top_i (
        .sys_clk         (sys_clk),
        .sys_rst_n       (sys_rst_n),
        .recv_done       (recv_done),
        .recv_data       (recv_data),
        .tx_busy         (tx_busy),
        .send_en         (send_en),
        .send_data       (send_data),
        .cap_set_res_1   (cap_set_res_1),
        .cap_set_res_2   (cap_set_res_2),
        .cap_set_support (cap_set_support)
    );

    // ----------------------------------------
    // echo monitor and transmitter model
    always @(posedge sys_clk) begin
        if (sys_rst_n && send_en) begin
            rx_q.push_back(send_data);
            strobe_cnt <= strobe_cnt + 1;
        end
    end

    always @(negedge sys_clk) begin
        if (served_cnt != strobe_cnt) begin
            served_cnt = strobe_cnt;
            tx_busy    = 1'b1;                        // busy from the next cycle
            busy_cnt   = 1 + ({$random(seed)} % 20);
        end else if (busy_cnt > 0) begin
            busy_cnt = busy_cnt - 1;
            if (busy_cnt == 0) begin
                tx_busy = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // helpers
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    task automatic send_byte(input byte_t b);
        int gap;
        gap = 1 + ({$random(seed)} % 4);
        @(negedge sys_clk);
        recv_data = b;
        recv_done = 1'b1;
        repeat (4) @(negedge sys_clk);
        recv_done = 1'b0;
        repeat (gap - 1) @(negedge sys_clk);
    endtask

    task automatic send_frame();
        foreach (frm[i]) begin
            send_byte(frm[i]);
        end
    endtask

    task automatic build_frame(input int len);
        frm = {HDR_BYTE_0, HDR_BYTE_1, byte_t'(len)};
        for (int i = 0; i < len; i++) begin
            frm.push_back(byte_t'($random(seed)));
        end
    endtask

    task automatic build_cmd(input int len, input byte_t code, input byte_t value);
        build_frame(len);
        frm[3] = code;
        if (len >= 2) begin
            frm[4] = value;
        end
    endtask

    // reference model: echo is the frame itself, command needs L of 2 or more
    task automatic predict();
        foreach (frm[i]) begin
            exp_q.push_back(frm[i]);
        end
        if (frm[2] >= 8'd2) begin
            if (frm[3] == 8'd1) exp_res_1 = frm[4];
            else if (frm[3] == 8'd2) exp_res_2 = frm[4];
            else if (frm[3] == 8'd3) exp_support = frm[4];
        end
    endtask

    task automatic check_caps(input string where);
        check(cap_set_res_1, exp_res_1, {where, " cap_set_res_1"});
        check(cap_set_res_2, exp_res_2, {where, " cap_set_res_2"});
        check(cap_set_support, exp_support, {where, " cap_set_support"});
    endtask

    task automatic wait_echo();
        int cnt;
        cnt = 0;
        while (rx_q.size() < exp_q.size() && cnt < exp_q.size() * 30 + 50) begin
            @(negedge sys_clk);
            cnt++;
        end
        repeat (40) @(negedge sys_clk);   // let the last busy and gap run out
        check(rx_q.size(), exp_q.size(), "echo byte count");
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check(rx_q[i], exp_q[i], $sformatf("echo byte %0d", i));
        end
        exp_q.delete();
        rx_q.delete();
        check_caps("after echo");
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %0d errors", name, error_count - errs_before);
    endtask

    // ----------------------------------------
    // stimulus
    initial begin : run_tests
        int    errs;
        byte_t b;
        byte_t code;
        byte_t value;

        repeat (16) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        repeat (2) @(negedge sys_clk);
        check(send_en, 1'b0, "send_en after reset");
        check_caps("after reset");

        // valid frames, random length and payload
        errs = error_count;
        for (int n = 0; n < 20; n++) begin
            build_frame(1 + ({$random(seed)} % MAX_PAYLOAD));
            predict();
            send_frame();
            wait_echo();
        end
        report_test("valid_frames", errs);

        // command frames with exact update timing
        errs = error_count;
        for (int n = 0; n < 9; n++) begin
            code  = byte_t'(1 + (n % 3));
            value = byte_t'($random(seed));
            build_cmd(2 + ({$random(seed)} % 6), code, value);
            for (int i = 0; i < frm.size() - 1; i++) begin
                send_byte(frm[i]);
            end
            @(negedge sys_clk);
            recv_data = frm[frm.size() - 1];
            recv_done = 1'b1;
            repeat (3) @(posedge sys_clk);
            @(negedge sys_clk);
            check_caps("3 cycles after last byte");   // old setpoints still held
            predict();
            @(negedge sys_clk);
            check_caps("4 cycles after last byte");
            recv_done = 1'b0;
            wait_echo();
        end
        report_test("command_frames", errs);

        // unknown codes and L of 1
        errs = error_count;
        for (int n = 0; n < 6; n++) begin
            if (n % 2 == 0) begin
                code = byte_t'(4 + ({$random(seed)} % 252));
                build_cmd(2 + ({$random(seed)} % 4), code, byte_t'($random(seed)));
            end else begin
                build_cmd(1, 8'd1, 8'h00);
            end
            predict();
            send_frame();
            wait_echo();
        end
        report_test("ignored_commands", errs);

        // bad frames and noise, then a good frame
        errs = error_count;
        for (int n = 0; n < 2; n++) begin
            b = byte_t'($random(seed));
            if (b == HDR_BYTE_1) b = 8'h00;
            frm = {HDR_BYTE_0, b};
            send_frame();
            frm = {HDR_BYTE_0, HDR_BYTE_1, 8'h00};
            send_frame();
            frm = {HDR_BYTE_0, HDR_BYTE_1, byte_t'(16 + ({$random(seed)} % 240))};
            send_frame();
            for (int i = 0; i < 3; i++) begin
                b = byte_t'($random(seed));
                if (b == HDR_BYTE_0) b = 8'h55;
                send_byte(b);
            end
            repeat (40) @(negedge sys_clk);
            check(rx_q.size(), 0, "no echo for bad frames");
            check_caps("after bad frames");
            build_frame(1 + ({$random(seed)} % MAX_PAYLOAD));
            predict();
            send_frame();
            wait_echo();
        end
        report_test("bad_frames", errs);

        // second frame arriving during an echo
        errs = error_count;
        for (int n = 0; n < 2; n++) begin
            build_frame(MAX_PAYLOAD);
            predict();
            send_frame();
            build_cmd(2, 8'd1, ~exp_res_1);   // would change res_1 if taken
            send_frame();
            wait_echo();
        end
        report_test("frame_during_echo", errs);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // ----------------------------------------
    // watchdog
    initial begin : watchdog
        #(NUM_FRAMES * FRAME_CYCLES * 10);
        $display("timeout: the tests did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
uart_frame_pkg.sv
pulse_ctrl_pkg.sv
frame_decoder.sv
frame_exec.sv
echo_sender.sv
uart_echo_top.sv
uart_echo_checker.sv
tb_uart_echo.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_echo
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation exited with status $$status"; exit 1; fi
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
